//--- bench/tb_soc.sv
// One transaction at a time; APB slave waits 0 to 3 cycles; L2 is read only after a full write
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module tb_soc;
  import soc_bus_pkg::*;

  localparam logic [63:0] DRAM_LO = 64'h8000_0000;
  localparam logic [63:0] DRAM_HI = 64'hC000_0000;
  localparam logic [63:0] UART_LO = 64'hC000_0000;
  localparam logic [63:0] CTRL_LO = 64'hD000_0000;
  localparam int          TIMEOUT = 40;

  logic                    clk_i;
  logic                    rst_i;
  logic                    bus_cmd_valid_i;
  logic                    bus_we_i;
  logic [`SOC_ADDR_W-1:0]  bus_addr_i;
  logic [`SOC_DATA_W-1:0]  bus_wdata_i;
  logic [`SOC_STRB_W-1:0]  bus_strb_i;
  logic                    bus_cmd_ready_o;
  logic                    bus_rsp_valid_o;
  logic                    bus_rsp_ready_i;
  logic [`SOC_DATA_W-1:0]  bus_rdata_o;
  bus_resp_e               bus_resp_o;
  logic [`SOC_DATA_W-1:0]  exit_o;
  logic [`SOC_DATA_W-1:0]  hw_cnt_en_o;
  logic                    uart_penable_o;
  logic                    uart_pwrite_o;
  logic [31:0]             uart_paddr_o;
  logic                    uart_psel_o;
  logic [`UART_DATA_W-1:0] uart_pwdata_o;
  logic [`UART_DATA_W-1:0] uart_prdata_i;
  logic                    uart_pready_i;
  logic                    uart_pslverr_i;

  integer      seed;
  logic [63:0] l2_model [`L2_WORDS];
  logic [63:0] exit_m;
  logic [63:0] hwcnt_m;
  bus_rsp_t    exp_q [$];
  bus_rsp_t    exp_now;
  int          apb_count;
  int          apb_before;
  int          apb_wait;
  logic [31:0] apb_addr;
  logic [31:0] apb_wdata;
  logic        apb_write;
  logic [63:0] addr;
  logic [63:0] data;
  logic [63:0] bad_addr [6];

  soc_top i_dut (.*);

  always #4 clk_i = ~clk_i;

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  function automatic logic [63:0] merge_bytes(
    input logic [63:0] old_val,
    input logic [63:0] new_val,
    input logic [7:0]  strb
  );
    logic [63:0] res;
    res = old_val;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

  // Reference response from the memory map and the model state
  function automatic bus_rsp_t expected_rsp(input logic we, input logic [63:0] a);
    bus_rsp_t    r;
    logic [31:0] prd;
    r.rdata = '0;
    r.resp  = OKAY;
    prd     = a[31:0] ^ 32'h5A5A_5A5A;
    if (a >= DRAM_LO && a < DRAM_HI) begin
      if (!we) r.rdata = l2_model[(a >> 3) % `L2_WORDS];
    end else if (a >= UART_LO && a < UART_LO + 64'h1000) begin
      if (a[11]) r.resp = SLVERR;
      if (!we) r.rdata = a[2] ? {prd, 32'h0} : {32'h0, prd};
    end else if (a >= CTRL_LO && a < CTRL_LO + 64'h1000) begin
      case (a[11:0])
        12'h000: r.rdata = exit_m;
        12'h008: r.rdata = hwcnt_m;
        12'h010: r.rdata = 64'h8000_0000;
        12'h018: r.rdata = 64'hC000_0000;
        default: r.resp  = SLVERR;
      endcase
      if (we) r.rdata = '0;
    end else begin
      r.resp = DECERR;
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, act, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: no %s", $time, what);
    $display("*** TEST FAILED ***");
    $fatal(1, "handshake stalled");
  endtask

  // Drive one command and optionally stall the response for hold cycles
  task automatic run_txn(input logic we, input logic [63:0] a, input logic [63:0] wd,
                         input logic [7:0] strb, input int hold);
    int          wait_cnt;
    logic [63:0] held_rdata;
    logic [1:0]  held_resp;
    @(posedge clk_i);
    bus_cmd_valid_i <= 1'b1;
    bus_we_i        <= we;
    bus_addr_i      <= a;
    bus_wdata_i     <= wd;
    bus_strb_i      <= strb;
    bus_rsp_ready_i <= (hold == 0);
    wait_cnt = 0;
    do begin
      @(posedge clk_i);
      wait_cnt++;
      if (wait_cnt > TIMEOUT) report_timeout("command accept on bus_cmd_ready_o");
    end while (!bus_cmd_ready_o);
    bus_cmd_valid_i <= 1'b0;
    if (hold > 0) begin
      wait_cnt = 0;
      do begin
        @(posedge clk_i);
        wait_cnt++;
        if (wait_cnt > TIMEOUT) report_timeout("response on bus_rsp_valid_o");
      end while (!bus_rsp_valid_o);
      held_rdata = bus_rdata_o;
      held_resp  = bus_resp_o;
      repeat (hold) begin
        @(posedge clk_i);
        check_value("bus_rsp_valid_o", bus_rsp_valid_o, 1);
        check_value("bus_rdata_o", bus_rdata_o, held_rdata);
        check_value("bus_resp_o", bus_resp_o, held_resp);
        check_value("bus_cmd_ready_o", bus_cmd_ready_o, 0);
      end
      bus_rsp_ready_i <= 1'b1;
    end
    wait_cnt = 0;
    do begin
      @(posedge clk_i);
      wait_cnt++;
      if (wait_cnt > TIMEOUT) report_timeout("response transfer");
    end while (!(bus_rsp_valid_o && bus_rsp_ready_i));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Response checker and model update
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (bus_rsp_valid_o && bus_rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Response at %0t ns with no command outstanding", $time);
          $display("*** TEST FAILED ***");
          $fatal(1, "unexpected response");
        end else begin
          exp_now = exp_q.pop_front();
          check_value("bus_rdata_o", bus_rdata_o, exp_now.rdata);
          check_value("bus_resp_o", bus_resp_o, exp_now.resp);
          check_value("exit_o", exit_o, exit_m);
          check_value("hw_cnt_en_o", hw_cnt_en_o, hwcnt_m);
        end
      end
      if (bus_cmd_valid_i && bus_cmd_ready_o) begin
        exp_q.push_back(expected_rsp(bus_we_i, bus_addr_i));
        if (bus_we_i && bus_addr_i >= DRAM_LO && bus_addr_i < DRAM_HI) begin
          l2_model[(bus_addr_i >> 3) % `L2_WORDS] =
            merge_bytes(l2_model[(bus_addr_i >> 3) % `L2_WORDS], bus_wdata_i, bus_strb_i);
        end
        if (bus_we_i && bus_addr_i == CTRL_LO) begin
          exit_m = merge_bytes(exit_m, bus_wdata_i, bus_strb_i);
        end
        if (bus_we_i && bus_addr_i == CTRL_LO + 64'h8) begin
          hwcnt_m = merge_bytes(hwcnt_m, bus_wdata_i, bus_strb_i);
        end
      end
    end
  end

  // APB slave
  always @(posedge clk_i) begin
    if (!rst_i && uart_psel_o && !uart_penable_o) begin
      apb_count++;
      apb_addr  = uart_paddr_o;
      apb_wdata = uart_pwdata_o;
      apb_write = uart_pwrite_o;
      apb_wait  = rand_below(4);
      repeat (apb_wait) @(posedge clk_i);
      uart_pready_i  <= 1'b1;
      uart_prdata_i  <= uart_paddr_o ^ 32'h5A5A_5A5A;
      uart_pslverr_i <= uart_paddr_o[11];
      @(posedge clk_i);
      check_value("uart_penable_o", uart_penable_o, 1);
      uart_pready_i  <= 1'b0;
      uart_pslverr_i <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed            = 33443;
    clk_i           = 1'b0;
    rst_i           = 1'b1;
    bus_cmd_valid_i = 1'b0;
    bus_we_i        = 1'b0;
    bus_addr_i      = '0;
    bus_wdata_i     = '0;
    bus_strb_i      = '0;
    bus_rsp_ready_i = 1'b1;
    uart_prdata_i   = '0;
    uart_pready_i   = 1'b0;
    uart_pslverr_i  = 1'b0;
    exit_m          = '0;
    hwcnt_m         = '0;
    apb_count       = 0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    check_value("exit_o", exit_o, 0);
    check_value("hw_cnt_en_o", hw_cnt_en_o, 0);
    check_value("uart_psel_o", uart_psel_o, 0);
    check_value("bus_rsp_valid_o", bus_rsp_valid_o, 0);
    check_value("bus_cmd_ready_o", bus_cmd_ready_o, 1);

    // L2 full write, strobed merge, read back and aliased read
    for (int i = 0; i < 16; i++) begin
      addr = DRAM_LO + rand_below(`L2_WORDS) * 8;
      data = {$random(seed), $random(seed)};
      run_txn(1'b1, addr, data, 8'hFF, rand_below(4));
      data = {$random(seed), $random(seed)};
      run_txn(1'b1, addr, data, $random(seed), rand_below(4));
      run_txn(1'b0, addr, '0, '0, rand_below(4));
      run_txn(1'b0, addr + (1 + rand_below(7)) * `L2_WORDS * 8, '0, '0, rand_below(4));
    end

    // Control registers
    for (int i = 0; i < 6; i++) begin
      run_txn(1'b1, CTRL_LO, {$random(seed), $random(seed)}, $random(seed), rand_below(4));
      run_txn(1'b1, CTRL_LO + 8, {$random(seed), $random(seed)}, $random(seed), rand_below(4));
      run_txn(1'b0, CTRL_LO, '0, '0, rand_below(4));
      run_txn(1'b0, CTRL_LO + 8, '0, '0, rand_below(4));
    end
    run_txn(1'b0, CTRL_LO + 64'h10, '0, '0, 0);
    run_txn(1'b1, CTRL_LO + 64'h18, '1, 8'hFF, 2);
    run_txn(1'b0, CTRL_LO + 64'h18, '0, '0, 0);
    run_txn(1'b1, CTRL_LO + 64'h20, '1, 8'hFF, 1);
    run_txn(1'b0, CTRL_LO + 64'h800, '0, '0, 3);

    // UART with bit 11 and bit 2 walked through all four cases
    for (int i = 0; i < 12; i++) begin
      addr = UART_LO + ({$random(seed)} & 32'h7F8) + ((i % 2) << 11) + (((i / 2) % 2) << 2);
      data = {$random(seed), $random(seed)};
      run_txn(1'b1, addr, data, 8'hFF, rand_below(4));
      check_value("uart_paddr_o", apb_addr, addr[31:0]);
      check_value("uart_pwdata_o", apb_wdata, addr[2] ? data[63:32] : data[31:0]);
      check_value("uart_pwrite_o", apb_write, 1);
      run_txn(1'b0, addr, '0, '0, rand_below(4));
      check_value("uart_paddr_o", apb_addr, addr[31:0]);
      check_value("uart_pwrite_o", apb_write, 0);
    end

    // Unmapped addresses
    bad_addr = '{64'h0, 64'h7FFF_FFF8, 64'hC000_1000, 64'hD000_1000,
                 64'hE000_0000, 64'h1_8000_0000};
    apb_before = apb_count;
    foreach (bad_addr[i]) begin
      run_txn(i % 2, bad_addr[i], '1, 8'hFF, rand_below(5));
    end
    check_value("APB access count", apb_count, apb_before);

    @(posedge clk_i);
    if (exp_q.size() != 0) begin
      $display("Commands left without a response: %0d", exp_q.size());
      $display("*** TEST FAILED ***");
      $fatal(1, "missing responses");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+logic
logic/soc_bus_pkg.sv
logic/soc_map_pkg.sv
logic/soc_bus_if.sv
logic/l2_mem.sv
logic/uart_apb_bridge.sv
logic/ctrl_registers.sv
logic/soc_xbar.sv
logic/soc_top.sv
bench/tb_soc.sv

//--- logic/ctrl_registers.sv
// Only the low 12 address bits are decoded; DRAM window registers are read-only
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module ctrl_registers (
  input  logic                   clk_i,
  input  logic                   rst_i,
  soc_bus_if.target              bus_t,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic [`SOC_DATA_W-1:0] hw_cnt_en_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [11:0]            ofs;
  logic [`SOC_DATA_W-1:0] exit_q;
  logic [`SOC_DATA_W-1:0] hw_cnt_q;
  logic [`SOC_DATA_W-1:0] rd_data;
  logic                   ofs_hit;
  logic                   pend_q;
  logic                   cmd_fire;
  bus_rsp_t               rsp_q;

  assign ofs             = bus_t.cmd.addr[11:0];
  assign bus_t.cmd_ready = !pend_q;
  assign cmd_fire        = bus_t.cmd_valid && bus_t.cmd_ready;

  always_comb begin
    ofs_hit = 1'b1;
    case (ofs)
      CTRL_EXIT_OFS:      rd_data = exit_q;
      CTRL_HWCNT_OFS:     rd_data = hw_cnt_q;
      CTRL_DRAM_BASE_OFS: rd_data = DRAM_BASE;
      CTRL_DRAM_END_OFS:  rd_data = DRAM_BASE + DRAM_LENGTH;
      default: begin
        rd_data = '0;
        ofs_hit = 1'b0;
      end
    endcase
  end

  // Writable registers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_q   <= '0;
      hw_cnt_q <= '0;
    end else if (cmd_fire && bus_t.cmd.we) begin
      if (ofs == CTRL_EXIT_OFS) begin
        exit_q <= strb_merge(exit_q, bus_t.cmd.wdata, bus_t.cmd.strb);
      end
      if (ofs == CTRL_HWCNT_OFS) begin
        hw_cnt_q <= strb_merge(hw_cnt_q, bus_t.cmd.wdata, bus_t.cmd.strb);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= 1'b0;
    end else if (cmd_fire) begin
      pend_q <= 1'b1;
    end else if (bus_t.rsp_ready) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      rsp_q.resp  <= ofs_hit ? OKAY : SLVERR;
      rsp_q.rdata <= bus_t.cmd.we ? '0 : rd_data;
    end
  end

  assign bus_t.rsp_valid = pend_q;
  assign bus_t.rsp       = rsp_q;
  assign exit_o          = exit_q;
  assign hw_cnt_en_o     = hw_cnt_q;

endmodule

`default_nettype wire

//--- logic/l2_mem.sv
// Word index ignores upper address bits, so contents repeat every L2_WORDS*8 bytes
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module l2_mem (
  input  logic      clk_i,
  input  logic      rst_i,
  soc_bus_if.target bus_t
);
  import soc_bus_pkg::*;

  localparam int IDX_W = $clog2(`L2_WORDS);
  localparam int OFS_W = $clog2(`SOC_STRB_W);

  logic [`SOC_DATA_W-1:0] mem_q [`L2_WORDS];
  logic [IDX_W-1:0]       idx;
  logic                   pend_q;
  logic                   cmd_fire;
  bus_rsp_t               rsp_q;

  assign idx            = bus_t.cmd.addr[OFS_W +: IDX_W];
  assign bus_t.cmd_ready = !pend_q;
  assign cmd_fire       = bus_t.cmd_valid && bus_t.cmd_ready;

  // Byte-merged write
  always_ff @(posedge clk_i) begin
    if (cmd_fire && bus_t.cmd.we) begin
      mem_q[idx] <= strb_merge(mem_q[idx], bus_t.cmd.wdata, bus_t.cmd.strb);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= 1'b0;
    end else if (cmd_fire) begin
      pend_q <= 1'b1;
    end else if (bus_t.rsp_ready) begin
      pend_q <= 1'b0;
    end
  end

  // Write acks carry no data
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      rsp_q.resp  <= OKAY;
      rsp_q.rdata <= bus_t.cmd.we ? '0 : mem_q[idx];
    end
  end

  assign bus_t.rsp_valid = pend_q;
  assign bus_t.rsp       = rsp_q;

  // Initiator never offers a command while this response is outstanding
  assert property (@(posedge clk_i) disable iff (rst_i)
    bus_t.rsp_valid |-> !bus_t.cmd_valid);

endmodule

`default_nettype wire

//--- logic/soc_bus_if.sv
// Valid/ready on both channels; valid and payload hold until the transfer
`timescale 1ns/10ps
`default_nettype none

interface soc_bus_if;
  import soc_bus_pkg::*;

  // Command channel
  logic     cmd_valid;
  logic     cmd_ready;
  bus_cmd_t cmd;

  // Response channel
  logic     rsp_valid;
  logic     rsp_ready;
  bus_rsp_t rsp;

  modport initiator (
    output cmd_valid, cmd, rsp_ready,
    input  cmd_ready, rsp_valid, rsp
  );

  modport target (
    input  cmd_valid, cmd, rsp_ready,
    output cmd_ready, rsp_valid, rsp
  );

endinterface

`default_nettype wire

//--- logic/soc_bus_pkg.sv
// Single-beat transactions only; no IDs, bursts or atomics
`default_nettype none

`include "soc_params.svh"

package soc_bus_pkg;

  // Subset of the AXI response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } bus_resp_e;

  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   we;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_STRB_W-1:0] strb;
  } bus_cmd_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    bus_resp_e              resp;
  } bus_rsp_t;

  // Byte lanes under strobe take the new data
  function automatic logic [`SOC_DATA_W-1:0] strb_merge(
    input logic [`SOC_DATA_W-1:0] old_data,
    input logic [`SOC_DATA_W-1:0] new_data,
    input logic [`SOC_STRB_W-1:0] strb
  );
    logic [`SOC_DATA_W-1:0] merged;
    merged = old_data;
    for (int i = 0; i < `SOC_STRB_W; i++) begin
      if (strb[i]) begin
        merged[i*8 +: 8] = new_data[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- logic/soc_map_pkg.sv
// Windows must not overlap; control offsets decode only the low 12 address bits
`default_nettype none

`include "soc_params.svh"

package soc_map_pkg;

  typedef enum logic [1:0] {
    L2MEM = 2'd0,
    UART  = 2'd1,
    CTRL  = 2'd2,
    NONE  = 2'd3
  } soc_region_e;

  // 1 GiB DRAM window, backed by the much smaller L2
  localparam logic [`SOC_ADDR_W-1:0] DRAM_BASE   = 64'h8000_0000;
  localparam logic [`SOC_ADDR_W-1:0] DRAM_LENGTH = 64'h4000_0000;

  localparam logic [`SOC_ADDR_W-1:0] UART_BASE   = 64'hC000_0000;
  localparam logic [`SOC_ADDR_W-1:0] UART_LENGTH = 64'h1000;

  localparam logic [`SOC_ADDR_W-1:0] CTRL_BASE   = 64'hD000_0000;
  localparam logic [`SOC_ADDR_W-1:0] CTRL_LENGTH = 64'h1000;

  // Control register offsets
  localparam logic [11:0] CTRL_EXIT_OFS      = 12'h000;
  localparam logic [11:0] CTRL_HWCNT_OFS     = 12'h008;
  localparam logic [11:0] CTRL_DRAM_BASE_OFS = 12'h010;
  localparam logic [11:0] CTRL_DRAM_END_OFS  = 12'h018;

endpackage

`default_nettype wire

//--- logic/soc_params.svh
// Bus widths are fixed at 64 bits; L2 size must be a power of two and aliases in DRAM
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// System bus
//////////////////////////////////////////////////////////////////////

`define SOC_ADDR_W 64
`define SOC_DATA_W 64

// One strobe per data byte
`define SOC_STRB_W 8

//////////////////////////////////////////////////////////////////////
// Peripherals
//////////////////////////////////////////////////////////////////////

// APB side of the UART bridge
`define UART_DATA_W 32

// Depth in 64-bit words, smaller than the DRAM window
// so the array repeats across it
`define L2_WORDS 1024

`endif

//--- logic/soc_top.sv
// Single external initiator, one outstanding transaction; UART latency depends on pready
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module soc_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    bus_cmd_valid_i,
  input  logic                    bus_we_i,
  input  logic [`SOC_ADDR_W-1:0]  bus_addr_i,
  input  logic [`SOC_DATA_W-1:0]  bus_wdata_i,
  input  logic [`SOC_STRB_W-1:0]  bus_strb_i,
  output logic                    bus_cmd_ready_o,
  output logic                    bus_rsp_valid_o,
  input  logic                    bus_rsp_ready_i,
  output logic [`SOC_DATA_W-1:0]  bus_rdata_o,
  output soc_bus_pkg::bus_resp_e  bus_resp_o,
  output logic [`SOC_DATA_W-1:0]  exit_o,
  output logic [`SOC_DATA_W-1:0]  hw_cnt_en_o,
  output logic                    uart_penable_o,
  output logic                    uart_pwrite_o,
  output logic [31:0]             uart_paddr_o,
  output logic                    uart_psel_o,
  output logic [`UART_DATA_W-1:0] uart_pwdata_o,
  input  logic [`UART_DATA_W-1:0] uart_prdata_i,
  input  logic                    uart_pready_i,
  input  logic                    uart_pslverr_i
);
  import soc_bus_pkg::*;

  bus_cmd_t cmd;
  bus_rsp_t rsp;

  soc_bus_if l2_bus ();
  soc_bus_if uart_bus ();
  soc_bus_if ctrl_bus ();

  assign cmd.addr    = bus_addr_i;
  assign cmd.we      = bus_we_i;
  assign cmd.wdata   = bus_wdata_i;
  assign cmd.strb    = bus_strb_i;
  assign bus_rdata_o = rsp.rdata;
  assign bus_resp_o  = rsp.resp;

  soc_xbar i_soc_xbar (
    .clk_i       (clk_i          ),
    .rst_i       (rst_i          ),
    .cmd_valid_i (bus_cmd_valid_i),
    .cmd_i       (cmd            ),
    .cmd_ready_o (bus_cmd_ready_o),
    .rsp_valid_o (bus_rsp_valid_o),
    .rsp_o       (rsp            ),
    .rsp_ready_i (bus_rsp_ready_i),
    .l2_o        (l2_bus         ),
    .uart_o      (uart_bus       ),
    .ctrl_o      (ctrl_bus       )
  );

  l2_mem i_l2_mem (
    .clk_i (clk_i ),
    .rst_i (rst_i ),
    .bus_t (l2_bus)
  );

  uart_apb_bridge i_uart_apb_bridge (
    .clk_i          (clk_i         ),
    .rst_i          (rst_i         ),
    .bus_t          (uart_bus      ),
    .uart_penable_o (uart_penable_o),
    .uart_pwrite_o  (uart_pwrite_o ),
    .uart_paddr_o   (uart_paddr_o  ),
    .uart_psel_o    (uart_psel_o   ),
    .uart_pwdata_o  (uart_pwdata_o ),
    .uart_prdata_i  (uart_prdata_i ),
    .uart_pready_i  (uart_pready_i ),
    .uart_pslverr_i (uart_pslverr_i)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .bus_t       (ctrl_bus   ),
    .exit_o      (exit_o     ),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

endmodule

`default_nettype wire

//--- logic/soc_xbar.sv
// One transaction in flight; unmapped addresses get DECERR one cycle after acceptance
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module soc_xbar (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cmd_valid_i,
  input  soc_bus_pkg::bus_cmd_t cmd_i,
  output logic                  cmd_ready_o,
  output logic                  rsp_valid_o,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  input  logic                  rsp_ready_i,
  soc_bus_if.initiator          l2_o,
  soc_bus_if.initiator          uart_o,
  soc_bus_if.initiator          ctrl_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  soc_region_e region;
  soc_region_e region_q;
  logic        busy_q;
  logic        tgt_ready;
  logic        cmd_fire;
  logic        rsp_fire;

  function automatic logic in_window(
    input logic [`SOC_ADDR_W-1:0] addr,
    input logic [`SOC_ADDR_W-1:0] base,
    input logic [`SOC_ADDR_W-1:0] len
  );
    return (addr >= base) && (addr < base + len);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (in_window(cmd_i.addr, DRAM_BASE, DRAM_LENGTH)) begin
      region = L2MEM;
    end else if (in_window(cmd_i.addr, UART_BASE, UART_LENGTH)) begin
      region = UART;
    end else if (in_window(cmd_i.addr, CTRL_BASE, CTRL_LENGTH)) begin
      region = CTRL;
    end else begin
      region = NONE;
    end
  end

  // Command goes out only while idle
  assign l2_o.cmd_valid   = cmd_valid_i && !busy_q && (region == L2MEM);
  assign uart_o.cmd_valid = cmd_valid_i && !busy_q && (region == UART);
  assign ctrl_o.cmd_valid = cmd_valid_i && !busy_q && (region == CTRL);
  assign l2_o.cmd         = cmd_i;
  assign uart_o.cmd       = cmd_i;
  assign ctrl_o.cmd       = cmd_i;

  always_comb begin
    case (region)
      L2MEM:   tgt_ready = l2_o.cmd_ready;
      UART:    tgt_ready = uart_o.cmd_ready;
      CTRL:    tgt_ready = ctrl_o.cmd_ready;
      default: tgt_ready = 1'b1;
    endcase
  end

  assign cmd_ready_o = !busy_q && tgt_ready;
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Response return
  //////////////////////////////////////////////////////////////////////

  assign l2_o.rsp_ready   = rsp_ready_i && busy_q && (region_q == L2MEM);
  assign uart_o.rsp_ready = rsp_ready_i && busy_q && (region_q == UART);
  assign ctrl_o.rsp_ready = rsp_ready_i && busy_q && (region_q == CTRL);

  always_comb begin
    rsp_valid_o = 1'b0;
    rsp_o.rdata = '0;
    rsp_o.resp  = DECERR;
    if (busy_q) begin
      case (region_q)
        L2MEM: begin
          rsp_valid_o = l2_o.rsp_valid;
          rsp_o       = l2_o.rsp;
        end
        UART: begin
          rsp_valid_o = uart_o.rsp_valid;
          rsp_o       = uart_o.rsp;
        end
        CTRL: begin
          rsp_valid_o = ctrl_o.rsp_valid;
          rsp_o       = ctrl_o.rsp;
        end
        // Decode error answered locally
        default: rsp_valid_o = 1'b1;
      endcase
    end
  end

  assign rsp_fire = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q   <= 1'b0;
      region_q <= NONE;
    end else if (cmd_fire) begin
      busy_q   <= 1'b1;
      region_q <= region;
    end else if (rsp_fire) begin
      busy_q   <= 1'b0;
    end
  end

  // Stalled response keeps its payload, whichever target it comes from
  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

`default_nettype wire

//--- logic/uart_apb_bridge.sv
// APB3 without strobes; one 32-bit half per access, chosen by address bit 2
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module uart_apb_bridge (
  input  logic                    clk_i,
  input  logic                    rst_i,
  soc_bus_if.target               bus_t,
  output logic                    uart_penable_o,
  output logic                    uart_pwrite_o,
  output logic [31:0]             uart_paddr_o,
  output logic                    uart_psel_o,
  output logic [`UART_DATA_W-1:0] uart_pwdata_o,
  input  logic [`UART_DATA_W-1:0] uart_prdata_i,
  input  logic                    uart_pready_i,
  input  logic                    uart_pslverr_i
);
  import soc_bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_RESP
  } state_e;

  state_e                  state_q;
  logic [31:0]             paddr_q;
  logic [`UART_DATA_W-1:0] pwdata_q;
  logic                    pwrite_q;
  logic                    hi_q;
  logic                    cmd_fire;
  bus_rsp_t                rsp_q;

  assign bus_t.cmd_ready = (state_q == ST_IDLE);
  assign bus_t.rsp_valid = (state_q == ST_RESP);
  assign bus_t.rsp       = rsp_q;
  assign cmd_fire        = bus_t.cmd_valid && bus_t.cmd_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:   if (cmd_fire) state_q <= ST_SETUP;
        ST_SETUP:  state_q <= ST_ACCESS;
        ST_ACCESS: if (uart_pready_i) state_q <= ST_RESP;
        ST_RESP:   if (bus_t.rsp_ready) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Capture the narrowed request
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      paddr_q  <= bus_t.cmd.addr[31:0];
      pwrite_q <= bus_t.cmd.we;
      hi_q     <= bus_t.cmd.addr[2];
      pwdata_q <= bus_t.cmd.addr[2] ? bus_t.cmd.wdata[63:32] : bus_t.cmd.wdata[31:0];
    end
  end

  // Widen read data back into the addressed half
  always_ff @(posedge clk_i) begin
    if (state_q == ST_ACCESS && uart_pready_i) begin
      rsp_q.resp <= uart_pslverr_i ? SLVERR : OKAY;
      if (pwrite_q) begin
        rsp_q.rdata <= '0;
      end else if (hi_q) begin
        rsp_q.rdata <= {uart_prdata_i, {`UART_DATA_W{1'b0}}};
      end else begin
        rsp_q.rdata <= {{`UART_DATA_W{1'b0}}, uart_prdata_i};
      end
    end
  end

  assign uart_psel_o    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign uart_penable_o = (state_q == ST_ACCESS);
  assign uart_pwrite_o  = pwrite_q;
  assign uart_paddr_o   = paddr_q;
  assign uart_pwdata_o  = pwdata_q;

  // Address, direction and data hold through the access phase
  assert property (@(posedge clk_i) disable iff (rst_i)
    uart_penable_o |-> $stable(uart_paddr_o) && $stable(uart_pwdata_o)
      && $stable(uart_pwrite_o));

endmodule

`default_nettype wire
